// File: rtl/sdrc_pkg.sv
/* shared widths, FIFO depths and payload types for the Wishbone to SDRAM bridge
   single transfer per command, no burst length field */
package sdrc_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------

  // application address, word granular
  localparam int APP_AW = 26;

  // data path
  localparam int DATA_W = 32;

  // one select bit per byte lane
  localparam int SEL_W = DATA_W / 8;

  // ----------------------------------------
  // FIFO depths
  // ----------------------------------------

  // command FIFO also bounds acked writes under back-pressure
  localparam int CMD_FIFO_DEPTH = 4;
  localparam int WR_FIFO_DEPTH  = 8;

  // only one read is ever outstanding, four is plenty
  localparam int RD_FIFO_DEPTH  = 4;

  // ----------------------------------------
  // payload types
  // ----------------------------------------

  typedef logic [APP_AW-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SEL_W-1:0]  sel_t;

  // request command, address plus direction
  typedef struct packed {
    addr_t addr;
    // 1 = read, 0 = write
    logic  wr_n;
  } sdr_cmd_t;

  // write data beat with active-low byte enables
  typedef struct packed {
    // low = lane written
    sel_t  wr_en_n;
    data_t data;
  } sdr_wr_t;

endpackage

// File: rtl/sdrc_fifo_if.sv
/* push/pop bundle of one FIFO; producer pushes only while full is low,
   consumer pops only while empty is low, rdata shows the head */
`timescale 1ns/1ps

interface sdrc_fifo_if #(
  parameter type T = logic
);

  // producer side
  logic push;
  T     wdata;
  logic full;

  // consumer side
  logic pop;
  T     rdata;
  logic empty;

  // writer of the queue
  modport push_mp (output push, output wdata, input full);

  // reader of the queue
  modport pop_mp (output pop, input rdata, input empty);

  // the FIFO itself
  modport fifo_mp (
    input  push,
    input  wdata,
    output full,
    input  pop,
    output rdata,
    output empty
  );

endinterface

// File: rtl/sdrc_sync_fifo.sv
/* show-ahead single-clock FIFO, head visible on rdata with no read delay
   push while full and pop while empty are ignored */
`timescale 1ns/1ps

module sdrc_sync_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input logic          sdram_clk,
  input logic          wb_clk_i,
  sdrc_fifo_if.fifo_mp f
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // ----------------------------------------
  // qualified strobes
  // ----------------------------------------
  assign wr_en = f.push && !f.full;
  assign rd_en = f.pop && !f.empty;

  // ----------------------------------------
  // storage and pointers
  // ----------------------------------------
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        mem[wr_ptr] <= f.wdata;
        // wrap at DEPTH, depth need not be a power of two
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // occupancy, push and pop together cancel out
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------------------
  // status and head
  // ----------------------------------------
  assign f.full  = (count == CNT_W'(DEPTH));
  assign f.empty = (count == '0);
  // head straight from the array
  assign f.rdata = mem[rd_ptr];

endmodule

// File: rtl/wb_req_ctrl.sv
/* Wishbone ack rules and request queuing; writes ack on FIFO room,
   reads ack only once their data is back, one read in flight */
`timescale 1ns/1ps

module wb_req_ctrl (
  input  logic            sdram_clk,
  input  logic            wb_clk_i,
  input  logic            wb_stb_i,
  input  logic            wb_cyc_i,
  input  logic            wb_we_i,
  input  sdrc_pkg::addr_t wb_addr_i,
  input  sdrc_pkg::data_t wb_dat_i,
  input  sdrc_pkg::sel_t  wb_sel_i,
  output logic            wb_ack_o,
  sdrc_fifo_if.push_mp    cmd,
  sdrc_fifo_if.push_mp    wr,
  sdrc_fifo_if.pop_mp     rd
);

  logic               wb_wr_req;
  logic               wb_rd_req;
  logic               wr_ack;
  logic               rd_ack;
  logic               rd_cmd_push;
  logic               pending_read;
  sdrc_pkg::sdr_cmd_t cmd_word;
  sdrc_pkg::sdr_wr_t  wr_word;

  // ----------------------------------------
  // decode of the current cycle
  // ----------------------------------------
  assign wb_wr_req = wb_stb_i && wb_cyc_i && wb_we_i;
  assign wb_rd_req = wb_stb_i && wb_cyc_i && !wb_we_i;

  // write needs room in both queues
  assign wr_ack = wb_wr_req && !cmd.full && !wr.full;
  // read completes once its data has landed
  assign rd_ack = wb_rd_req && !rd.empty;

  assign wb_ack_o = wr_ack || rd_ack;

  // read command goes out once per pending period
  assign rd_cmd_push = wb_rd_req && !pending_read && !cmd.full;

  // ----------------------------------------
  // pending read tracker
  // ----------------------------------------
  // set on command push, cleared on the read ack edge
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      pending_read <= 1'b0;
    end else if (rd_cmd_push) begin
      pending_read <= 1'b1;
    end else if (rd_ack) begin
      pending_read <= 1'b0;
    end
  end

  // ----------------------------------------
  // command payload
  // ----------------------------------------
  always_comb begin
    cmd_word.addr = wb_addr_i;
    // direction flag is the inverted write enable
    cmd_word.wr_n = !wb_we_i;
  end

  assign cmd.push  = wr_ack || rd_cmd_push;
  assign cmd.wdata = cmd_word;

  // ----------------------------------------
  // write data payload
  // ----------------------------------------
  always_comb begin
    // controller wants active-low lane enables
    wr_word.wr_en_n = ~wb_sel_i;
    wr_word.data    = wb_dat_i;
  end

  // data rides along with its write command
  assign wr.push  = wr_ack;
  assign wr.wdata = wr_word;

  // read data leaves the FIFO with the ack
  assign rd.pop = rd_ack;

endmodule

// File: rtl/wb2sdrc.sv
/* Wishbone slave to SDRAM controller request bridge, one clock domain
   single-beat transfers only, one read outstanding at a time */
`timescale 1ns/1ps

module wb2sdrc (
  input  logic             sdram_clk,
  input  logic             wb_clk_i,
  // Wishbone slave
  input  logic             wb_stb_i,
  input  logic             wb_cyc_i,
  input  logic             wb_we_i,
  input  sdrc_pkg::addr_t  wb_addr_i,
  input  sdrc_pkg::data_t  wb_dat_i,
  input  sdrc_pkg::sel_t   wb_sel_i,
  output logic             wb_ack_o,
  output sdrc_pkg::data_t  wb_dat_o,
  // SDRAM controller request side
  output logic             sdr_req_o,
  output sdrc_pkg::addr_t  sdr_req_addr_o,
  output logic             sdr_req_wr_n_o,
  input  logic             sdr_req_ack_i,
  output sdrc_pkg::sel_t   sdr_wr_en_n_o,
  output sdrc_pkg::data_t  sdr_wr_data_o,
  input  logic             sdr_wr_next_i,
  input  logic             sdr_rd_valid_i,
  input  sdrc_pkg::data_t  sdr_rd_data_i
);

  // ----------------------------------------
  // FIFO bundles
  // ----------------------------------------
  sdrc_fifo_if #(.T(sdrc_pkg::sdr_cmd_t)) cmd_if ();
  sdrc_fifo_if #(.T(sdrc_pkg::sdr_wr_t))  wr_if ();
  sdrc_fifo_if #(.T(sdrc_pkg::data_t))    rd_if ();

  // Wishbone side control
  wb_req_ctrl u_req_ctrl (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .wb_stb_i  (wb_stb_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_we_i   (wb_we_i),
    .wb_addr_i (wb_addr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .wb_ack_o  (wb_ack_o),
    .cmd       (cmd_if.push_mp),
    .wr        (wr_if.push_mp),
    .rd        (rd_if.pop_mp)
  );

  // ----------------------------------------
  // command FIFO, address plus direction
  // ----------------------------------------
  sdrc_sync_fifo #(
    .T     (sdrc_pkg::sdr_cmd_t),
    .DEPTH (sdrc_pkg::CMD_FIFO_DEPTH)
  ) u_cmdfifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .f         (cmd_if.fifo_mp)
  );

  // request held while anything is queued
  assign sdr_req_o      = !cmd_if.empty;
  assign sdr_req_addr_o = cmd_if.rdata.addr;
  assign sdr_req_wr_n_o = cmd_if.rdata.wr_n;
  // controller ack retires the head command
  assign cmd_if.pop     = sdr_req_ack_i;

  // ----------------------------------------
  // write data FIFO, data plus byte enables
  // ----------------------------------------
  sdrc_sync_fifo #(
    .T     (sdrc_pkg::sdr_wr_t),
    .DEPTH (sdrc_pkg::WR_FIFO_DEPTH)
  ) u_wrdatafifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .f         (wr_if.fifo_mp)
  );

  assign sdr_wr_en_n_o = wr_if.rdata.wr_en_n;
  assign sdr_wr_data_o = wr_if.rdata.data;
  // one beat consumed per wr_next
  assign wr_if.pop     = sdr_wr_next_i;

  // ----------------------------------------
  // read data FIFO, back to Wishbone
  // ----------------------------------------
  sdrc_sync_fifo #(
    .T     (sdrc_pkg::data_t),
    .DEPTH (sdrc_pkg::RD_FIFO_DEPTH)
  ) u_rddatafifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .f         (rd_if.fifo_mp)
  );

  // no back-pressure toward the controller
  assign rd_if.push  = sdr_rd_valid_i;
  assign rd_if.wdata = sdr_rd_data_i;
  // head is valid in the read ack cycle
  assign wb_dat_o    = rd_if.rdata;

endmodule

// File: testbench/tb_wb2sdrc.sv
/* drives the bridge through Wishbone accesses against an SDRAM controller model
   memory outside written words reads back a fill pattern built from the address */
`timescale 1ns/1ps

module tb_wb2sdrc;

  // watchdog budget counts one entry per Wishbone access
  localparam int NUM_OPS = 2 + 2 + 3 + 10 + 200;

  logic             sdram_clk = 1'b0;
  logic             wb_clk_i = 1'b1;
  logic             wb_stb_i;
  logic             wb_cyc_i;
  logic             wb_we_i;
  sdrc_pkg::addr_t  wb_addr_i;
  sdrc_pkg::data_t  wb_dat_i;
  sdrc_pkg::sel_t   wb_sel_i;
  logic             wb_ack_o;
  sdrc_pkg::data_t  wb_dat_o;
  logic             sdr_req_o;
  sdrc_pkg::addr_t  sdr_req_addr_o;
  logic             sdr_req_wr_n_o;
  logic             sdr_req_ack_i;
  sdrc_pkg::sel_t   sdr_wr_en_n_o;
  sdrc_pkg::data_t  sdr_wr_data_o;
  logic             sdr_wr_next_i;
  logic             sdr_rd_valid_i;
  sdrc_pkg::data_t  sdr_rd_data_i;

  // controller model state
  logic                stall = 1'b0;
  int unsigned         rd_extra = 0;
  int unsigned         rd_cmd_count = 0;
  int unsigned         read_count = 0;
  logic [31:0]         lfsr_state = 32'h2174;
  sdrc_pkg::data_t     model_mem [sdrc_pkg::addr_t];
  sdrc_pkg::data_t     ref_mem [sdrc_pkg::addr_t];
  sdrc_pkg::sdr_cmd_t  exp_cmd_q [$];
  sdrc_pkg::sdr_wr_t   exp_wr_q [$];

  wb2sdrc UUT (.*);

  always #4 sdram_clk = ~sdram_clk;

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // unwritten words
  function automatic sdrc_pkg::data_t fill_word(input sdrc_pkg::addr_t a);
    return {6'h15, a};
  endfunction

  // expected word after a masked write
  function automatic sdrc_pkg::data_t ref_merge(input sdrc_pkg::data_t old_w,
      input sdrc_pkg::data_t new_w, input sdrc_pkg::sel_t sel);
    sdrc_pkg::data_t r;
    r = old_w;
    for (int b = 0; b < sdrc_pkg::SEL_W; b++) begin
      if (sel[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  function automatic sdrc_pkg::data_t ref_word(input sdrc_pkg::addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  function automatic sdrc_pkg::data_t model_word(input sdrc_pkg::addr_t a);
    return model_mem.exists(a) ? model_mem[a] : fill_word(a);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, got);
      abort_run("control output has the wrong level");
    end
  endtask

  task automatic check_data(input string name, input sdrc_pkg::data_t exp,
      input sdrc_pkg::data_t got);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, got);
      abort_run("read data differs from the reference memory");
    end
  endtask

  task automatic check_cmd(input sdrc_pkg::sdr_cmd_t exp, input sdrc_pkg::sdr_cmd_t got);
    if (got !== exp) begin
      $display("ERROR at %0t ns: sdr_req_addr_o/sdr_req_wr_n_o expected %h/%b, got %h/%b",
               $time, exp.addr, exp.wr_n, got.addr, got.wr_n);
      abort_run("request command differs from the Wishbone access");
    end
  endtask

  task automatic check_wr(input sdrc_pkg::sdr_wr_t exp, input sdrc_pkg::sdr_wr_t got);
    if (got !== exp) begin
      $display("ERROR at %0t ns: sdr_wr_en_n_o/sdr_wr_data_o expected %h/%h, got %h/%h",
               $time, exp.wr_en_n, exp.data, got.wr_en_n, got.data);
      abort_run("write beat differs from the Wishbone write");
    end
  endtask

  // ----------------------------------------
  // Wishbone driver
  // ----------------------------------------
  // starts and returns 1 ns after a rising edge
  task automatic wb_cycle(input logic we, input sdrc_pkg::addr_t addr,
      input sdrc_pkg::data_t data, input sdrc_pkg::sel_t sel, output sdrc_pkg::data_t rdata);
    wb_stb_i  = 1'b1;
    wb_cyc_i  = 1'b1;
    wb_we_i   = we;
    wb_addr_i = addr;
    wb_dat_i  = data;
    wb_sel_i  = sel;
    // ack is combinational so sample it mid cycle
    @(negedge sdram_clk);
    while (!wb_ack_o) @(negedge sdram_clk);
    rdata = wb_dat_o;
    @(posedge sdram_clk);
    #1;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input sdrc_pkg::addr_t addr, input sdrc_pkg::data_t data,
      input sdrc_pkg::sel_t sel);
    sdrc_pkg::sdr_cmd_t c;
    sdrc_pkg::sdr_wr_t  w;
    sdrc_pkg::data_t    unused;
    c.addr    = addr;
    c.wr_n    = 1'b0;
    w.wr_en_n = ~sel;
    w.data    = data;
    exp_cmd_q.push_back(c);
    exp_wr_q.push_back(w);
    ref_mem[addr] = ref_merge(ref_word(addr), data, sel);
    wb_cycle(1'b1, addr, data, sel, unused);
  endtask

  task automatic wb_read(input sdrc_pkg::addr_t addr);
    sdrc_pkg::sdr_cmd_t c;
    sdrc_pkg::data_t    got;
    c.addr = addr;
    c.wr_n = 1'b1;
    exp_cmd_q.push_back(c);
    read_count++;
    wb_cycle(1'b0, addr, '0, '1, got);
    check_data("wb_dat_o", ref_word(addr), got);
  endtask

  // ----------------------------------------
  // SDRAM controller model
  // ----------------------------------------
  initial begin : sdram_model
    sdrc_pkg::sdr_cmd_t got_cmd;
    sdrc_pkg::sdr_wr_t  got_wr;
    sdrc_pkg::data_t    word;
    int unsigned        delay;
    @(negedge wb_clk_i);
    forever begin
      @(negedge sdram_clk);
      if (sdr_req_o && !stall) begin
        got_cmd.addr = sdr_req_addr_o;
        got_cmd.wr_n = sdr_req_wr_n_o;
        if (exp_cmd_q.size() == 0) abort_run("request seen with no Wishbone access behind it");
        else check_cmd(exp_cmd_q.pop_front(), got_cmd);
        delay = rand_bits(2);
        repeat (delay) @(posedge sdram_clk);
        @(posedge sdram_clk);
        #1 sdr_req_ack_i = 1'b1;
        @(posedge sdram_clk);
        #1 sdr_req_ack_i = 1'b0;
        if (!got_cmd.wr_n) begin
          // data beat follows the ack
          @(negedge sdram_clk);
          got_wr.wr_en_n = sdr_wr_en_n_o;
          got_wr.data    = sdr_wr_data_o;
          check_wr(exp_wr_q.pop_front(), got_wr);
          word = model_word(got_cmd.addr);
          for (int b = 0; b < sdrc_pkg::SEL_W; b++) begin
            if (!got_wr.wr_en_n[b]) word[8*b +: 8] = got_wr.data[8*b +: 8];
          end
          model_mem[got_cmd.addr] = word;
          @(posedge sdram_clk);
          #1 sdr_wr_next_i = 1'b1;
          @(posedge sdram_clk);
          #1 sdr_wr_next_i = 1'b0;
        end else begin
          rd_cmd_count++;
          delay = rand_bits(2) + rd_extra;
          repeat (delay) @(posedge sdram_clk);
          @(posedge sdram_clk);
          #1;
          sdr_rd_valid_i = 1'b1;
          sdr_rd_data_i  = model_word(got_cmd.addr);
          @(posedge sdram_clk);
          #1 sdr_rd_valid_i = 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin : watchdog
    #(NUM_OPS * 20 * 8);
    abort_run("watchdog timeout, the Wishbone accesses did not finish in time");
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin : stimulus
    wb_stb_i       = 1'b0;
    wb_cyc_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_addr_i      = '0;
    wb_dat_i       = '0;
    wb_sel_i       = '0;
    sdr_req_ack_i  = 1'b0;
    sdr_wr_next_i  = 1'b0;
    sdr_rd_valid_i = 1'b0;
    sdr_rd_data_i  = '0;
    repeat (5) @(posedge sdram_clk);
    #1 wb_clk_i = 1'b0;
    // idle outputs straight after reset
    @(negedge sdram_clk);
    check_bit("wb_ack_o", 1'b0, wb_ack_o);
    check_bit("sdr_req_o", 1'b0, sdr_req_o);
    @(posedge sdram_clk);
    #1;
    // full word then partial write
    wb_write(26'h10, 32'hDEAD_BEEF, 4'hF);
    wb_read(26'h10);
    wb_write(26'h10, 32'h1234_5678, 4'b0101);
    wb_read(26'h10);
    // slow read data must still give one command per read
    rd_extra = 12;
    wb_read(26'h20);
    wb_read(26'h10);
    wb_read(26'h21);
    rd_extra = 0;
    if (rd_cmd_count != read_count) abort_run("read commands do not match Wishbone reads");
    // with the controller stalled only four writes fit in the command FIFO
    stall = 1'b1;
    for (int i = 0; i < 4; i++) begin
      wb_write(26'h40 + sdrc_pkg::addr_t'(i), 32'hC0DE_0000 + i, 4'hF);
    end
    fork
      wb_write(26'h44, 32'hC0DE_0004, 4'b1100);
      begin
        repeat (6) begin
          @(negedge sdram_clk);
          check_bit("wb_ack_o", 1'b0, wb_ack_o);
        end
        @(posedge sdram_clk);
        #1 stall = 1'b0;
      end
    join
    for (int i = 0; i < 5; i++) begin
      wb_read(26'h40 + sdrc_pkg::addr_t'(i));
    end
    // random traffic over eight words
    for (int n = 0; n < 200; n++) begin
      if (rand_bits(1) != 0) begin
        wb_write(26'h100 + sdrc_pkg::addr_t'(rand_bits(3)), rand_bits(32),
                 sdrc_pkg::sel_t'(rand_bits(4)));
      end else begin
        wb_read(26'h100 + sdrc_pkg::addr_t'(rand_bits(3)));
      end
    end
    // trailing writes still have their command and beat to be compared
    while (exp_cmd_q.size() != 0 || exp_wr_q.size() != 0) begin
      @(posedge sdram_clk);
    end
    if (rd_cmd_count == read_count) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abort_run("read commands do not match Wishbone reads at the end");
    end
  end

endmodule

// File: wb2sdrc.f
rtl/sdrc_pkg.sv
rtl/sdrc_fifo_if.sv
rtl/sdrc_sync_fifo.sv
rtl/wb_req_ctrl.sv
rtl/wb2sdrc.sv
testbench/tb_wb2sdrc.sv

// File: Makefile
# Verilator build and run for the Wishbone to SDRAM request bridge

VERILATOR := verilator
TOP       := tb_wb2sdrc
FILELIST  := wb2sdrc.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --top-module $(TOP) -Mdir $(OBJ_DIR)
LOG       := sim.log
PASS_MSG  := SIMULATION PASSED

SOURCES   := $(wildcard rtl/*.sv) $(wildcard testbench/*.sv)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the log search decides pass or fail
run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
